//--- apb_regs.sv
`timescale 1ns/10ps

module apb_regs
    import nabp_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [paddr_width-1:0]  paddr,
    input  logic [pdata_width-1:0]  pwdata,
    output logic [pdata_width-1:0]  prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  logic                    hs_next_angle,
    input  logic                    busy,
    input  logic                    scan_mode,
    output logic [angle_width-1:0]  hs_angle,
    output logic                    hs_next_angle_ack,
    output logic                    ram_we,
    output logic [idx_width-1:0]    ram_waddr,
    output logic [sample_width-1:0] ram_wdata
);

    logic access;
    logic sel_status;
    logic sel_angle;
    logic sel_sample;
    logic angle_ok;
    logic access_ok;
    logic [paddr_width-1:0] sample_off;

    // no wait states
    assign pready = 1'b1;
    assign access = psel && penable;

    assign sel_status = (paddr == reg_status);
    assign sel_angle = (paddr == reg_angle);
    assign sample_off = paddr - reg_sample_base;
    assign sel_sample = (paddr >= reg_sample_base)
                     && (sample_off < paddr_width'(4 * proj_len))
                     && (paddr[1:0] == 2'b00);

    // angle accepted only when the controller is waiting for one
    assign angle_ok = hs_next_angle && (pwdata < num_angles);

    assign hs_next_angle_ack = access && pwrite && sel_angle && angle_ok;

    assign ram_we = access && pwrite && sel_sample;
    assign ram_waddr = sample_off[idx_width+1:2];
    assign ram_wdata = pwdata[sample_width-1:0];

    // status is read only, samples are write only
    assign access_ok = (sel_status && !pwrite)
                    || (sel_angle && (!pwrite || angle_ok))
                    || (sel_sample && pwrite);
    assign pslverr = access && !access_ok;

    always_comb
    begin
        prdata = '0;
        if (sel_status)
        begin
            prdata[status_next_angle] = hs_next_angle;
            prdata[status_scan_mode] = scan_mode;
            prdata[status_busy] = busy;
        end
        else if (sel_angle)
        begin
            prdata[angle_width-1:0] = hs_angle;
        end
    end

    // angle register, read back through the angle address
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            hs_angle <= '0;
        end
        else if (hs_next_angle_ack)
        begin
            hs_angle <= pwdata[angle_width-1:0];
        end
    end

endmodule

//--- filtered_ram.sv
`timescale 1ns/10ps

module filtered_ram
    import nabp_pkg::*;
(
    input  logic                    clk,
    input  logic                    we,
    input  logic [idx_width-1:0]    waddr,
    input  logic [sample_width-1:0] wdata,
    input  logic [idx_width-1:0]    raddr,
    output logic [sample_width-1:0] rdata
);

    logic [sample_width-1:0] mem [proj_len];

    // host writes, swappables read one cycle later
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

//--- nabp_pkg.sv
package nabp_pkg;

    // angles in whole degrees, 0 to 179
    localparam int angle_width = 8;
    localparam int num_angles = 180;
    localparam int angle_45 = 45;
    localparam int angle_135 = 135;

    // one filtered projection line
    localparam int proj_len = 16;
    localparam int idx_width = 4;
    localparam int sample_width = 12;
    localparam int num_itr = 4;
    localparam int itr_width = 2;

    // tap offset is center + swing * cos(angle), truncated
    localparam real offset_center = 8.0;
    localparam real offset_swing = 7.0;
    localparam real deg_to_rad = 3.14159265358979 / 180.0;

    localparam logic scan_x = 1'b0;
    localparam logic scan_y = 1'b1;

    // apb bus and register map
    localparam int paddr_width = 8;
    localparam int pdata_width = 32;
    localparam logic [paddr_width-1:0] reg_status = 8'h00;
    localparam logic [paddr_width-1:0] reg_angle = 8'h04;
    localparam logic [paddr_width-1:0] reg_sample_base = 8'h40;

    // status register bits
    localparam int status_next_angle = 0;
    localparam int status_scan_mode = 1;
    localparam int status_busy = 2;

    // x scan near the horizontal, y scan near the vertical
    function automatic logic scan_mode_of(input logic [angle_width-1:0] angle);
        return (angle < angle_45 || angle >= angle_135) ? scan_x : scan_y;
    endfunction

endpackage

//--- nabp_top.f
nabp_pkg.sv
apb_regs.sv
filtered_ram.sv
shifter_lut.sv
swappable.sv
swap_control.sv
nabp_top.sv
nabp_top_sva.sv
nabp_top_tb.sv

//--- nabp_top.sv
`timescale 1ns/10ps

module nabp_top
    import nabp_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [paddr_width-1:0]  paddr,
    input  logic [pdata_width-1:0]  pwdata,
    output logic [pdata_width-1:0]  prdata,
    output logic                    pready,
    output logic                    pslverr,
    output logic [sample_width-1:0] pe_taps,
    output logic                    pe_en,
    output logic                    pe_kick,
    output logic                    pe_reset,
    output logic                    pe_scan_mode
);

    logic                    hs_next_angle;
    logic                    hs_next_angle_ack;
    logic [angle_width-1:0]  hs_angle;
    logic                    busy;
    logic                    ram_we;
    logic [idx_width-1:0]    ram_waddr;
    logic [sample_width-1:0] ram_wdata;
    logic [idx_width-1:0]    ram_raddr;
    logic [sample_width-1:0] ram_rdata;
    logic [idx_width-1:0]    offset;
    logic                    sw_sel;
    logic                    sw0_swap;
    logic                    sw1_swap;
    logic                    sw0_next_itr;
    logic                    sw1_next_itr;
    logic                    sw0_swap_ack;
    logic                    sw1_swap_ack;
    logic                    sw0_next_itr_ack;
    logic                    sw1_next_itr_ack;
    logic                    sw0_pe_en;
    logic                    sw1_pe_en;
    logic [idx_width-1:0]    sw0_raddr;
    logic [idx_width-1:0]    sw1_raddr;
    logic [sample_width-1:0] sw0_taps;
    logic [sample_width-1:0] sw1_taps;

    // filling unit owns the ram read port, streaming unit owns the taps
    assign ram_raddr = sw_sel ? sw0_raddr : sw1_raddr;
    assign pe_taps = sw_sel ? sw1_taps : sw0_taps;
    assign pe_en = sw_sel ? sw1_pe_en : sw0_pe_en;

    apb_regs regs_i (
        .clk(clk), .reset_n(reset_n),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .hs_next_angle(hs_next_angle), .busy(busy), .scan_mode(pe_scan_mode),
        .hs_angle(hs_angle), .hs_next_angle_ack(hs_next_angle_ack),
        .ram_we(ram_we), .ram_waddr(ram_waddr), .ram_wdata(ram_wdata)
    );

    filtered_ram ram_i (
        .clk(clk), .we(ram_we), .waddr(ram_waddr), .wdata(ram_wdata),
        .raddr(ram_raddr), .rdata(ram_rdata)
    );

    shifter_lut lut_i (
        .clk(clk), .angle(hs_angle), .offset(offset)
    );

    swap_control ctrl_i (
        .clk(clk), .reset_n(reset_n),
        .hs_angle(hs_angle), .hs_next_angle_ack(hs_next_angle_ack),
        .sw0_swap(sw0_swap), .sw1_swap(sw1_swap),
        .sw0_next_itr(sw0_next_itr), .sw1_next_itr(sw1_next_itr),
        .sw0_swap_ack(sw0_swap_ack), .sw1_swap_ack(sw1_swap_ack),
        .sw0_next_itr_ack(sw0_next_itr_ack), .sw1_next_itr_ack(sw1_next_itr_ack),
        .sw_sel(sw_sel), .hs_next_angle(hs_next_angle), .busy(busy),
        .pe_reset(pe_reset), .pe_kick(pe_kick), .pe_scan_mode(pe_scan_mode)
    );

    swappable sw0 (
        .clk(clk), .reset_n(reset_n),
        .next_itr_ack(sw0_next_itr_ack), .swap_ack(sw0_swap_ack),
        .offset(offset), .rdata(ram_rdata), .raddr(sw0_raddr), .taps(sw0_taps),
        .swap(sw0_swap), .next_itr(sw0_next_itr), .pe_en_out(sw0_pe_en)
    );

    swappable sw1 (
        .clk(clk), .reset_n(reset_n),
        .next_itr_ack(sw1_next_itr_ack), .swap_ack(sw1_swap_ack),
        .offset(offset), .rdata(ram_rdata), .raddr(sw1_raddr), .taps(sw1_taps),
        .swap(sw1_swap), .next_itr(sw1_next_itr), .pe_en_out(sw1_pe_en)
    );

endmodule

//--- nabp_top_sva.sv
`timescale 1ns/10ps

module nabp_top_sva
    import nabp_pkg::*;
(
    input logic clk,
    input logic reset_n,
    input logic psel,
    input logic penable,
    input logic pslverr,
    input logic pe_en,
    input logic pe_kick,
    input logic pe_reset
);

    localparam int stream_len = num_itr * proj_len;

    logic [6:0] en_left;
    int failures = 0;

    // cycles of the current stream still to come
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            en_left <= '0;
        end
        else if (pe_kick)
        begin
            en_left <= 7'(stream_len);
        end
        else if (en_left != '0)
        begin
            en_left <= en_left - 1'b1;
        end
    end

    kick_starts_stream: assert property (@(posedge clk) disable iff (!reset_n)
        pe_kick |=> pe_en)
    else
    begin
        failures++;
        $error("pe_en not high in the cycle after pe_kick");
    end

    stream_has_no_gap: assert property (@(posedge clk) disable iff (!reset_n)
        (en_left != '0) |-> pe_en)
    else
    begin
        failures++;
        $error("pe_en dropped inside a 64 cycle stream");
    end

    // a refused access never starts a new angle
    error_in_access_phase: assert property (@(posedge clk) disable iff (!reset_n)
        pslverr |-> (psel && penable && !pe_reset))
    else
    begin
        failures++;
        $error("pslverr raised outside an APB access phase or together with pe_reset");
    end

endmodule

//--- nabp_top_tb.sv
`timescale 1ns/10ps

module nabp_top_tb
    import nabp_pkg::*;
;

    // 10 random, 4 boundary, 1 in the error test, 6 back to back
    localparam int total_angles = 21;
    localparam int limit_cycles = total_angles * 200 + 2000;

    logic                    clk;
    logic                    reset_n;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [paddr_width-1:0]  paddr;
    logic [pdata_width-1:0]  pwdata;
    logic [pdata_width-1:0]  prdata;
    logic                    pready;
    logic                    pslverr;
    logic [sample_width-1:0] pe_taps;
    logic                    pe_en;
    logic                    pe_kick;
    logic                    pe_reset;
    logic                    pe_scan_mode;

    int seed = 75003;
    int errors = 0;
    int check_errors = 0;
    int accepted = 0;
    int kicks = 0;
    int overlaps = 0;
    int taps_checked = 0;
    int test_count = 0;
    logic reset_seen = 1'b0;
    logic [sample_width-1:0] saved_line [proj_len];
    logic [sample_width-1:0] exp_taps [$];
    logic exp_modes [$];

    nabp_top dut_i (
        .clk(clk), .reset_n(reset_n),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .pe_taps(pe_taps), .pe_en(pe_en), .pe_kick(pe_kick),
        .pe_reset(pe_reset), .pe_scan_mode(pe_scan_mode)
    );

    bind nabp_top nabp_top_sva sva_i (
        .clk(clk), .reset_n(reset_n),
        .psel(psel), .penable(penable), .pslverr(pslverr),
        .pe_en(pe_en), .pe_kick(pe_kick), .pe_reset(pe_reset)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // tap j of iteration k is sample (j + k * offset) mod 16
    function automatic logic [sample_width-1:0] expected_tap(input int angle, input int itr,
                                                             input int tap);
        real cosine;
        int shift;
        cosine = $cos(real'(angle) * 3.141592653589793 / 180.0);
        // tiny bias absorbs cosine rounding where 7 cos(a) is whole
        shift = $rtoi(8.0 + 7.0 * cosine + 1.0e-9);
        return saved_line[idx_width'((tap + itr * shift) % proj_len)];
    endfunction

    function automatic int total_errors();
        return errors + check_errors + dut_i.sva_i.failures;
    endfunction

    task automatic write_reg(input logic [paddr_width-1:0] addr,
                             input logic [pdata_width-1:0] data, output logic err);
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b1;
        paddr <= addr;
        pwdata <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        err = pslverr;
        reset_seen = pe_reset;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic read_reg(input logic [paddr_width-1:0] addr,
                            output logic [pdata_width-1:0] data, output logic err);
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b0;
        paddr <= addr;
        pwdata <= '0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        err = pslverr;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic load_line();
        logic err;
        for (int n = 0; n < proj_len; n++)
        begin
            saved_line[idx_width'(n)] = sample_width'($random(seed));
            write_reg(reg_sample_base + paddr_width'(4 * n),
                      pdata_width'(saved_line[idx_width'(n)]), err);
            assert (!err) else
            begin
                errors++;
                $display("Sample write %0d was refused with pslverr", n);
            end
        end
    endtask

    // accepted angles queue their scan mode and 64 taps
    task automatic send_angle(input int angle, input logic expect_err);
        logic err;
        write_reg(reg_angle, pdata_width'(angle), err);
        assert (err == expect_err) else
        begin
            errors++;
            $display("Mismatch pslverr: got 0x%h, expected 0x%h for angle 0x%h",
                     err, expect_err, angle);
        end
        // pe_reset pulses in the access phase of an accepted angle only
        assert (reset_seen == !expect_err) else
        begin
            errors++;
            $display("Mismatch pe_reset: got 0x%h, expected 0x%h for angle 0x%h",
                     reset_seen, !expect_err, angle);
        end
        if (!err)
        begin
            accepted++;
            exp_modes.push_back((angle < angle_45 || angle >= angle_135) ? scan_x : scan_y);
            for (int k = 0; k < num_itr; k++)
            begin
                for (int j = 0; j < proj_len; j++)
                begin
                    exp_taps.push_back(expected_tap(angle, k, j));
                end
            end
        end
    endtask

    task automatic check_refused(input logic err, input string what);
        assert (err) else
        begin
            errors++;
            $display("Access to %s was not refused with pslverr", what);
        end
    endtask

    task automatic wait_ready();
        logic [pdata_width-1:0] status;
        logic err;
        status = '0;
        while (!status[status_next_angle])
        begin
            read_reg(reg_status, status, err);
        end
    endtask

    task automatic wait_drained();
        while (exp_taps.size() != 0)
        begin
            @(posedge clk);
        end
        @(posedge clk);
    endtask

    task automatic finish_test(input string name, input int start);
        test_count++;
        $display("test %0d %s: %0d error(s)", test_count, name, total_errors() - start);
    endtask

    // compare streamed taps and kick-time scan mode in mid-cycle
    initial
    begin
        logic [sample_width-1:0] want;
        logic want_mode;
        forever
        begin
            @(negedge clk);
            if (reset_n)
            begin
                // no wait states on any access
                if (psel && penable)
                begin
                    assert (pready) else
                    begin
                        check_errors++;
                        $display("Mismatch pready: got 0x%h, expected 0x1", pready);
                    end
                end
                if (pe_reset && pe_en)
                begin
                    overlaps++;
                end
                if (pe_kick)
                begin
                    kicks++;
                    assert (exp_modes.size() != 0) else
                    begin
                        check_errors++;
                        $display("pe_kick seen with no accepted angle pending");
                    end
                    if (exp_modes.size() != 0)
                    begin
                        want_mode = exp_modes.pop_front();
                        assert (pe_scan_mode == want_mode) else
                        begin
                            check_errors++;
                            $display("Mismatch pe_scan_mode: got 0x%h, expected 0x%h",
                                     pe_scan_mode, want_mode);
                        end
                    end
                end
                if (pe_en)
                begin
                    assert (exp_taps.size() != 0) else
                    begin
                        check_errors++;
                        $display("pe_en high with no taps left to stream");
                    end
                    if (exp_taps.size() != 0)
                    begin
                        want = exp_taps.pop_front();
                        assert (pe_taps == want) else
                        begin
                            check_errors++;
                            $display("Mismatch pe_taps: got 0x%h, expected 0x%h at tap %0d",
                                     pe_taps, want, taps_checked);
                        end
                        taps_checked++;
                    end
                end
            end
        end
    end

    initial
    begin
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", limit_cycles);
        $display("Errors found");
        $finish;
    end

    initial
    begin
        logic [pdata_width-1:0] status;
        logic err;
        int start;
        int angle;
        int boundary [4];
        int kick_mark;
        boundary = '{44, 45, 134, 135};
        reset_n <= 1'b0;
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
        paddr <= '0;
        pwdata <= '0;
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;

        start = total_errors();
        read_reg(reg_status, status, err);
        @(negedge clk);
        assert (status == 32'h1 && !err) else
        begin
            errors++;
            $display("Mismatch status: got 0x%h, expected 0x%h", status, 32'h1);
        end
        assert (!pe_en) else
        begin
            errors++;
            $display("Mismatch pe_en: got 0x%h, expected 0x0", pe_en);
        end
        finish_test("reset status", start);

        start = total_errors();
        for (int i = 0; i < 10; i++)
        begin
            wait_ready();
            load_line();
            angle = int'($unsigned($random(seed)) % num_angles);
            send_angle(angle, 1'b0);
            wait_drained();
        end
        finish_test("random lines and angles", start);

        start = total_errors();
        foreach (boundary[i])
        begin
            wait_ready();
            load_line();
            send_angle(boundary[i], 1'b0);
            wait_drained();
        end
        finish_test("scan mode at boundary angles", start);

        // refused accesses leave the next stream untouched
        start = total_errors();
        wait_ready();
        write_reg(8'h08, 32'h0, err);
        check_refused(err, "unmapped address 0x08");
        read_reg(8'h80, status, err);
        check_refused(err, "unmapped address 0x80");
        send_angle(180, 1'b1);
        send_angle(200, 1'b1);
        load_line();
        send_angle(90, 1'b0);
        send_angle(30, 1'b1);
        wait_drained();
        finish_test("refused accesses", start);

        // next angle goes in as soon as the status allows it
        start = total_errors();
        kick_mark = overlaps;
        for (int i = 0; i < 6; i++)
        begin
            wait_ready();
            load_line();
            angle = int'($unsigned($random(seed)) % num_angles);
            send_angle(angle, 1'b0);
        end
        wait_drained();
        assert (kicks == accepted) else
        begin
            errors++;
            $display("Saw %0d pe_kick pulses for %0d accepted angles", kicks, accepted);
        end
        assert (overlaps > kick_mark) else
        begin
            errors++;
            $display("No angle was accepted while a stream was running");
        end
        assert (exp_modes.size() == 0) else
        begin
            errors++;
            $display("%0d accepted angles never reached pe_kick", exp_modes.size());
        end
        finish_test("back-to-back angles", start);

        $display("summary: %0d tests, %0d angles accepted, %0d taps checked, %0d errors",
                 test_count, accepted, taps_checked, total_errors());
        if (total_errors() == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- run.sh
#!/bin/sh
# build and run the nabp_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module nabp_top_tb -f nabp_top.f -o nabp_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# keep running past assertion errors so the testbench reaches its verdict
out=$(./obj_dir/nabp_sim +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^No errors$"; then
    exit 0
fi
exit 1

//--- shifter_lut.sv
`timescale 1ns/10ps

module shifter_lut
    import nabp_pkg::*;
(
    input  logic                   clk,
    input  logic [angle_width-1:0] angle,
    output logic [idx_width-1:0]   offset
);

    logic [idx_width-1:0] rom [num_angles];

    // 8 + 7 cos(a) stays within 1..15, so truncation is a plain floor
    initial
    begin
        for (int a = 0; a < num_angles; a++)
        begin
            rom[a] = idx_width'($rtoi(offset_center
                                    + offset_swing * $cos(a * deg_to_rad)));
        end
    end

    // registered lookup, one cycle behind the angle
    always_ff @(posedge clk)
    begin
        offset <= rom[angle];
    end

endmodule

//--- swap_control.sv
`timescale 1ns/10ps

module swap_control
    import nabp_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic [angle_width-1:0] hs_angle,
    input  logic                   hs_next_angle_ack,
    input  logic                   sw0_swap,
    input  logic                   sw1_swap,
    input  logic                   sw0_next_itr,
    input  logic                   sw1_next_itr,
    output logic                   sw0_swap_ack,
    output logic                   sw1_swap_ack,
    output logic                   sw0_next_itr_ack,
    output logic                   sw1_next_itr_ack,
    output logic                   sw_sel,
    output logic                   hs_next_angle,
    output logic                   busy,
    output logic                   pe_reset,
    output logic                   pe_kick,
    output logic                   pe_scan_mode
);

    typedef enum logic [1:0] {
        st_ready,
        st_setup,
        st_fill,
        st_fill_and_shift
    } state_t;

    state_t state;
    state_t next_state;
    logic fill_swap;
    logic shift_next_itr;
    logic angle_ack;
    logic swap_ack;
    logic [1:0] scan_stage;

    // sw_sel picks the streaming unit, the other one fills
    assign fill_swap = sw_sel ? sw0_swap : sw1_swap;
    assign shift_next_itr = sw_sel ? sw1_next_itr : sw0_next_itr;

    assign angle_ack = (state == st_ready) && hs_next_angle_ack;
    assign swap_ack = (state == st_fill || state == st_fill_and_shift)
                   && fill_swap && shift_next_itr;

    assign sw0_next_itr_ack = angle_ack && sw_sel;
    assign sw1_next_itr_ack = angle_ack && !sw_sel;
    assign sw0_swap_ack = swap_ack && sw_sel;
    assign sw1_swap_ack = swap_ack && !sw_sel;

    assign busy = (state != st_ready);
    assign pe_reset = angle_ack;
    assign pe_kick = swap_ack;
    // during the kick cycle show the unit about to stream
    assign pe_scan_mode = scan_stage[sw_sel ^ swap_ack];

    always_comb
    begin
        next_state = state;
        case (state)
            st_ready:
                if (angle_ack)
                begin
                    next_state = st_setup;
                end
            st_setup:
                next_state = shift_next_itr ? st_fill : st_fill_and_shift;
            st_fill:
                if (swap_ack)
                begin
                    next_state = st_ready;
                end
            st_fill_and_shift:
                if (swap_ack)
                begin
                    next_state = st_ready;
                end
                else if (shift_next_itr)
                begin
                    next_state = st_fill;
                end
            default:
                next_state = st_ready;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= st_ready;
            sw_sel <= 1'b0;
            hs_next_angle <= 1'b0;
            scan_stage <= '0;
        end
        else
        begin
            state <= next_state;
            hs_next_angle <= (next_state == st_ready);
            if (swap_ack)
            begin
                sw_sel <= !sw_sel;
            end
            // mode for the filling unit, angle register valid by now
            if (state == st_setup)
            begin
                scan_stage[!sw_sel] <= scan_mode_of(hs_angle);
            end
        end
    end

endmodule

//--- swappable.sv
`timescale 1ns/10ps

module swappable
    import nabp_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    next_itr_ack,
    input  logic                    swap_ack,
    input  logic [idx_width-1:0]    offset,
    input  logic [sample_width-1:0] rdata,
    output logic [idx_width-1:0]    raddr,
    output logic [sample_width-1:0] taps,
    output logic                    swap,
    output logic                    next_itr,
    output logic                    pe_en_out
);

    typedef enum logic [1:0] {
        mode_idle,
        mode_fill,
        mode_full,
        mode_shift
    } mode_t;

    mode_t mode;
    logic [idx_width:0]      fill_cnt;
    logic [idx_width-1:0]    wr_idx;
    logic [idx_width-1:0]    tap_idx;
    logic [idx_width-1:0]    itr_base;
    logic [itr_width-1:0]    itr_cnt;
    logic [idx_width-1:0]    offset_q;
    logic [sample_width-1:0] line_buf [proj_len];

    // read address leads the buffer write by the ram latency
    assign raddr = fill_cnt[idx_width-1:0];
    assign wr_idx = fill_cnt[idx_width-1:0] - 1'b1;

    assign swap = (mode == mode_full);
    assign next_itr = (mode == mode_idle);
    assign pe_en_out = (mode == mode_shift);

    // tap j of iteration k, base already holds k * offset mod 16
    assign taps = line_buf[tap_idx + itr_base];

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            mode <= mode_idle;
            fill_cnt <= '0;
            tap_idx <= '0;
            itr_base <= '0;
            itr_cnt <= '0;
        end
        else
        begin
            case (mode)
                mode_idle:
                    if (next_itr_ack)
                    begin
                        mode <= mode_fill;
                        fill_cnt <= '0;
                    end
                mode_fill:
                begin
                    fill_cnt <= fill_cnt + 1'b1;
                    if (fill_cnt == (idx_width + 1)'(proj_len))
                    begin
                        mode <= mode_full;
                    end
                end
                mode_full:
                    if (swap_ack)
                    begin
                        mode <= mode_shift;
                        tap_idx <= '0;
                        itr_base <= '0;
                        itr_cnt <= '0;
                    end
                mode_shift:
                begin
                    // tap index wraps to 0 at the end of each iteration
                    tap_idx <= tap_idx + 1'b1;
                    if (tap_idx == idx_width'(proj_len - 1))
                    begin
                        itr_cnt <= itr_cnt + 1'b1;
                        itr_base <= itr_base + offset_q;
                        if (itr_cnt == itr_width'(num_itr - 1))
                        begin
                            mode <= mode_idle;
                        end
                    end
                end
                default:
                    mode <= mode_idle;
            endcase
        end
    end

    // line buffer and the offset for this line
    always_ff @(posedge clk)
    begin
        if (mode == mode_fill && fill_cnt != '0)
        begin
            line_buf[wr_idx] <= rdata;
        end
        // lut output settled long before the last sample lands
        if (mode == mode_fill && fill_cnt == (idx_width + 1)'(proj_len))
        begin
            offset_q <= offset;
        end
    end

endmodule
